//--- logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

   localparam int ghsr_width    = 10;                  // global history length
   localparam int pht_width     = 10;
   localparam int pht_size      = 1 << pht_width;      // 2-bit counters
   localparam int btb_width     = 6;
   localparam int btb_size      = 1 << btb_width;
   localparam int btb_tag_width = 32 - btb_width - 2;  // pc bits above index, 24

   localparam logic [1:0] counter_reset = 2'b10;       // weakly taken

   // gshare hash, word pc xor history
   function automatic logic [pht_width-1:0] pht_index(
      input logic [31:0]           pc,
      input logic [ghsr_width-1:0] ghsr
   );
      return pc[pht_width+1:2] ^ ghsr;
   endfunction

   function automatic logic counter_taken(input logic [1:0] ctr);
      return ctr[1];  // 2 and 3 predict taken
   endfunction

   // saturating step, no wrap at either end
   function automatic logic [1:0] counter_update(
      input logic [1:0] ctr,
      input logic       taken
   );
      if (taken) begin
         return (ctr == 2'b11) ? 2'b11 : ctr + 2'b01;
      end
      return (ctr == 2'b00) ? 2'b00 : ctr - 2'b01;
   endfunction

endpackage

`default_nettype wire

//--- logic/gshare_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module gshare_predictor (
   input  wire logic                           clk,
   input  wire logic                           reset_n,
   input  wire logic [31:0]                    fetch_pc,
   input  wire logic                           fetch_valid,
   input  wire logic                           slot0_hit,
   input  wire logic                           slot1_hit,
   input  wire logic                           apply,
   input  wire logic [31:0]                    resolve_pc,
   input  wire logic                           resolve_taken,
   input  wire logic                           resolve_mispredict,
   input  wire logic                           resolve_btb_miss,
   input  wire logic [bp_pkg::ghsr_width-1:0]  resolve_ghsr,
   output logic                                slot0_taken,
   output logic                                slot1_taken,
   output logic      [bp_pkg::ghsr_width-1:0]  ghsr_checkpoint
);

   localparam int hw = bp_pkg::ghsr_width;

   logic [1:0]                    pht [bp_pkg::pht_size];
   logic [hw-1:0]                 ghsr;
   logic [hw-1:0]                 ghsr_next;
   logic [hw-1:0]                 restore_base;  // resolve_ghsr plus outcome
   logic [hw-1:0]                 shift_base;    // history the fetch shift lands on
   logic [hw-1:0]                 spec_ghsr;
   logic                          spec_update;
   logic [31:0]                   slot1_pc;
   logic [bp_pkg::pht_width-1:0]  slot0_idx;
   logic [bp_pkg::pht_width-1:0]  slot1_idx;
   logic [bp_pkg::pht_width-1:0]  update_idx;

   // pht read, both slots hashed with the current history
   assign slot1_pc  = fetch_pc + 32'd4;
   assign slot0_idx = bp_pkg::pht_index(fetch_pc, ghsr);
   assign slot1_idx = bp_pkg::pht_index(slot1_pc, ghsr);

   assign slot0_taken = bp_pkg::counter_taken(pht[slot0_idx]);
   assign slot1_taken = bp_pkg::counter_taken(pht[slot1_idx]);

   assign ghsr_checkpoint = ghsr;  // travels with the fetch pair

   // history only moves when some slot hits the btb
   assign spec_update  = fetch_valid && (slot0_hit || slot1_hit);
   assign restore_base = {resolve_ghsr[hw-2:0], resolve_taken};

   // a btb miss corrects the base but keeps this cycle's fetch shift
   assign shift_base = (apply && resolve_btb_miss) ? restore_base : ghsr;

   always_comb begin
      if (slot0_hit && slot0_taken) begin
         spec_ghsr = {shift_base[hw-2:0], 1'b1};
      end else if (slot0_hit && slot1_hit && slot1_taken) begin
         spec_ghsr = {shift_base[hw-3:0], 2'b01};  // slot 0 not taken, then slot 1 taken
      end else if (slot1_hit && slot1_taken) begin
         spec_ghsr = {shift_base[hw-2:0], 1'b1};
      end else if (slot0_hit) begin
         spec_ghsr = {shift_base[hw-2:0], 1'b0};
      end else begin
         spec_ghsr = shift_base;
      end
   end

   always_comb begin
      if (apply && resolve_mispredict) begin
         ghsr_next = restore_base;  // fetch is flushed, ignore its shift
      end else if (spec_update) begin
         ghsr_next = spec_ghsr;
      end else begin
         ghsr_next = shift_base;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ghsr <= '0;
      end else begin
         ghsr <= ghsr_next;
      end
   end

   // training uses the history the branch was predicted with
   assign update_idx = bp_pkg::pht_index(resolve_pc, resolve_ghsr);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < bp_pkg::pht_size; i++) begin
            pht[i] <= bp_pkg::counter_reset;
         end
      end else if (apply) begin
         pht[update_idx] <= bp_pkg::counter_update(pht[update_idx], resolve_taken);
      end
   end

endmodule

`default_nettype wire

//--- logic/branch_target_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer (
   input  wire logic         clk,
   input  wire logic         reset_n,
   input  wire logic [31:0]  fetch_pc,
   input  wire logic         slot0_taken,
   input  wire logic         slot1_taken,
   input  wire logic         apply,
   input  wire logic [31:0]  resolve_pc,
   input  wire logic         resolve_taken,
   input  wire logic [31:0]  resolve_target,
   output logic              slot0_hit,
   output logic              slot1_hit,
   output logic      [31:0]  next_pc
);

   localparam int iw = bp_pkg::btb_width;
   localparam int tw = bp_pkg::btb_tag_width;

   logic [bp_pkg::btb_size-1:0]  valid_bits;
   logic [tw-1:0]                tag_mem    [bp_pkg::btb_size];
   logic [31:0]                  target_mem [bp_pkg::btb_size];

   logic [31:0]    slot_pc     [2];
   logic [iw-1:0]  slot_idx    [2];
   logic [31:0]    slot_target [2];
   logic [1:0]     slot_hit;
   logic [iw-1:0]  wr_idx;
   logic           wr_en;

   assign slot_pc[0] = fetch_pc;
   assign slot_pc[1] = fetch_pc + 32'd4;  // second word of the pair

   // two read ports, same lookup per slot
   for (genvar s = 0; s < 2; s++) begin : g_lookup
      assign slot_idx[s]    = slot_pc[s][iw+1:2];
      assign slot_hit[s]    = valid_bits[slot_idx[s]] &&
                              (tag_mem[slot_idx[s]] == slot_pc[s][31:32-tw]);
      assign slot_target[s] = target_mem[slot_idx[s]];
   end

   assign slot0_hit = slot_hit[0];
   assign slot1_hit = slot_hit[1];

   // first taken slot in program order redirects fetch
   always_comb begin
      if (slot_hit[0] && slot0_taken) begin
         next_pc = slot_target[0];
      end else if (slot_hit[1] && slot1_taken) begin
         next_pc = slot_target[1];
      end else begin
         next_pc = fetch_pc + 32'd8;
      end
   end

   // only taken branches allocate, an older entry at the index is replaced
   assign wr_en  = apply && resolve_taken;
   assign wr_idx = resolve_pc[iw+1:2];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         valid_bits <= '0;
      end else if (wr_en) begin
         valid_bits[wr_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[wr_idx]    <= resolve_pc[31:32-tw];
         target_mem[wr_idx] <= resolve_target;
      end
   end

endmodule

`default_nettype wire

//--- logic/resolve_port.sv
`timescale 1ns/10ps
`default_nettype none

module resolve_port (
   input  wire logic  clk,
   input  wire logic  reset_n,
   input  wire logic  resolve_req,
   output logic       resolve_ack,
   output logic       apply
);

   typedef enum logic {
      st_idle,
      st_busy   // ack raised, waiting for req to drop
   } port_state_t;

   port_state_t state;
   port_state_t state_next;

   // one strobe per request, busy blocks a held req
   assign apply       = (state == st_idle) && resolve_req;
   assign resolve_ack = (state == st_busy);

   always_comb begin
      state_next = state;
      case (state)
         st_idle: if (resolve_req) state_next = st_busy;
         st_busy: if (!resolve_req) state_next = st_idle;  // ack falls next edge
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

endmodule

`default_nettype wire

//--- logic/fetch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_predictor (
   input  wire logic                           clk,
   input  wire logic                           reset_n,
   // fetch side
   input  wire logic [31:0]                    fetch_pc,
   input  wire logic                           fetch_valid,
   output logic                                slot0_hit,
   output logic                                slot1_hit,
   output logic                                slot0_taken,
   output logic                                slot1_taken,
   output logic      [31:0]                    next_pc,
   output logic      [bp_pkg::ghsr_width-1:0]  ghsr_checkpoint,
   // resolution side
   input  wire logic                           resolve_req,
   output logic                                resolve_ack,
   input  wire logic [31:0]                    resolve_pc,
   input  wire logic                           resolve_taken,
   input  wire logic [31:0]                    resolve_target,
   input  wire logic                           resolve_mispredict,
   input  wire logic                           resolve_btb_miss,
   input  wire logic [bp_pkg::ghsr_width-1:0]  resolve_ghsr
);

   logic apply;  // one cycle per resolution

   resolve_port u_resolve_port (
      .clk         (clk),
      .reset_n     (reset_n),
      .resolve_req (resolve_req),
      .resolve_ack (resolve_ack),
      .apply       (apply)
   );

   gshare_predictor u_gshare_predictor (
      .clk                (clk),
      .reset_n            (reset_n),
      .fetch_pc           (fetch_pc),
      .fetch_valid        (fetch_valid),
      .slot0_hit          (slot0_hit),
      .slot1_hit          (slot1_hit),
      .apply              (apply),
      .resolve_pc         (resolve_pc),
      .resolve_taken      (resolve_taken),
      .resolve_mispredict (resolve_mispredict),
      .resolve_btb_miss   (resolve_btb_miss),
      .resolve_ghsr       (resolve_ghsr),
      .slot0_taken        (slot0_taken),
      .slot1_taken        (slot1_taken),
      .ghsr_checkpoint    (ghsr_checkpoint)
   );

   // hits feed the history, raw directions feed next-pc select
   branch_target_buffer u_branch_target_buffer (
      .clk            (clk),
      .reset_n        (reset_n),
      .fetch_pc       (fetch_pc),
      .slot0_taken    (slot0_taken),
      .slot1_taken    (slot1_taken),
      .apply          (apply),
      .resolve_pc     (resolve_pc),
      .resolve_taken  (resolve_taken),
      .resolve_target (resolve_target),
      .slot0_hit      (slot0_hit),
      .slot1_hit      (slot1_hit),
      .next_pc        (next_pc)
   );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
   output logic clk,
   output logic reset_n
);

   initial clk = 1'b0;
   always #10 clk = ~clk;  // 20 ns period

   initial begin
      reset_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- verification/bp_model.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// mirror of the predictor state, stepped on the rising edge
logic [hw-1:0] m_ghsr;
logic [1:0]    m_pht    [bp_pkg::pht_size];
logic          m_valid  [bp_pkg::btb_size];
logic [23:0]   m_tag    [bp_pkg::btb_size];
logic [31:0]   m_target [bp_pkg::btb_size];
logic          m_busy;  // ack state of the handshake

function automatic logic [9:0] hashed_index(input logic [31:0] pc, input logic [hw-1:0] h);
   return pc[11:2] ^ h;
endfunction

function automatic logic btb_hit(input logic [31:0] pc);
   return m_valid[pc[7:2]] && (m_tag[pc[7:2]] == pc[31:8]);
endfunction

function automatic logic counter_dir(input logic [31:0] pc);
   return m_pht[hashed_index(pc, m_ghsr)][1];
endfunction

function automatic logic [31:0] predicted_next_pc(input logic [31:0] pc);
   logic [31:0] pc1;
   pc1 = pc + 32'd4;
   if (btb_hit(pc) && counter_dir(pc)) return m_target[pc[7:2]];
   if (btb_hit(pc1) && counter_dir(pc1)) return m_target[pc1[7:2]];
   return pc + 32'd8;
endfunction

// speculative shift of one fetch pair onto a base history
function automatic logic [hw-1:0] shifted_history(
   input logic [hw-1:0] base,
   input logic [31:0]   pc
);
   logic h0;
   logic h1;
   logic t0;
   logic t1;
   h0 = btb_hit(pc);
   h1 = btb_hit(pc + 32'd4);
   t0 = counter_dir(pc);
   t1 = counter_dir(pc + 32'd4);
   if (h0 && t0) return {base[hw-2:0], 1'b1};
   if (h0 && h1 && t1) return {base[hw-3:0], 2'b01};
   if (h1 && t1) return {base[hw-2:0], 1'b1};
   if (h0) return {base[hw-2:0], 1'b0};
   return base;
endfunction

function automatic logic [1:0] saturate_counter(input logic [1:0] c, input logic up);
   if (up) return (c == 2'd3) ? c : c + 2'd1;
   return (c == 2'd0) ? c : c - 2'd1;
endfunction

`endif

//--- verification/fetch_predictor_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_predictor_tb;

   localparam int hw = bp_pkg::ghsr_width;

   logic          clk;
   logic          reset_n;
   logic [31:0]   fetch_pc;
   logic          fetch_valid;
   logic          slot0_hit;
   logic          slot1_hit;
   logic          slot0_taken;
   logic          slot1_taken;
   logic [31:0]   next_pc;
   logic [hw-1:0] ghsr_checkpoint;
   logic          resolve_req;
   logic          resolve_ack;
   logic [31:0]   resolve_pc;
   logic          resolve_taken;
   logic [31:0]   resolve_target;
   logic          resolve_mispredict;
   logic          resolve_btb_miss;
   logic [hw-1:0] resolve_ghsr;
   logic [31:0]   lfsr;
   int            errors;
   int            checks;
   int            test_errors;

   `include "bp_model.svh"

   clock_gen clock_gen0 (.clk(clk), .reset_n(reset_n));

   fetch_predictor dut0 (.*);

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois step
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // mirror update, same priority as the execute-side correction
   always @(posedge clk) begin
      logic apply;
      logic [hw-1:0] base;
      logic [hw-1:0] nxt;
      if (!reset_n) begin
         m_ghsr = '0;
         m_busy = 1'b0;
         for (int i = 0; i < bp_pkg::pht_size; i++) m_pht[i] = 2'b10;
         for (int i = 0; i < bp_pkg::btb_size; i++) m_valid[i] = 1'b0;
      end else begin
         apply = !m_busy && resolve_req;
         base = {resolve_ghsr[hw-2:0], resolve_taken};
         nxt = (apply && resolve_btb_miss) ? base : m_ghsr;
         if (apply && resolve_mispredict) nxt = base;
         else if (fetch_valid && (btb_hit(fetch_pc) || btb_hit(fetch_pc + 32'd4)))
            nxt = shifted_history(nxt, fetch_pc);
         if (apply) begin
            m_pht[hashed_index(resolve_pc, resolve_ghsr)] =
               saturate_counter(m_pht[hashed_index(resolve_pc, resolve_ghsr)], resolve_taken);
            if (resolve_taken) begin
               m_valid[resolve_pc[7:2]] = 1'b1;
               m_tag[resolve_pc[7:2]] = resolve_pc[31:8];
               m_target[resolve_pc[7:2]] = resolve_target;
            end
         end
         m_busy = resolve_req;
         m_ghsr = nxt;
      end
   end

   task automatic expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   // compare process, just after the falling-edge drive
   always @(negedge clk) begin
      #1;
      if (reset_n) begin
         expect_value("slot0_hit", 32'(slot0_hit), 32'(btb_hit(fetch_pc)));
         expect_value("slot1_hit", 32'(slot1_hit), 32'(btb_hit(fetch_pc + 32'd4)));
         expect_value("slot0_taken", 32'(slot0_taken), 32'(counter_dir(fetch_pc)));
         expect_value("slot1_taken", 32'(slot1_taken), 32'(counter_dir(fetch_pc + 32'd4)));
         expect_value("next_pc", next_pc, predicted_next_pc(fetch_pc));
         expect_value("ghsr_checkpoint", 32'(ghsr_checkpoint), 32'(m_ghsr));
         expect_value("resolve_ack", 32'(resolve_ack), 32'(m_busy));
      end
   end

   task automatic send_resolution(input logic [31:0] pc, input logic taken,
                                  input logic [31:0] target, input logic mis,
                                  input logic miss, input logic [hw-1:0] gh, input int hold);
      int n;
      @(negedge clk);
      resolve_pc = pc;
      resolve_taken = taken;
      resolve_target = target;
      resolve_mispredict = mis;
      resolve_btb_miss = miss;
      resolve_ghsr = gh;
      resolve_req = 1'b1;
      n = 0;
      while (resolve_ack !== 1'b1 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (resolve_ack !== 1'b1) begin
         errors++;
         $display("timeout: resolve_ack never rose after the request");
      end
      repeat (hold) @(negedge clk);  // slow requester keeps req high
      resolve_req = 1'b0;
      n = 0;
      while (resolve_ack !== 1'b0 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (resolve_ack !== 1'b0) begin
         errors++;
         $display("timeout: resolve_ack stayed high after the request dropped");
      end
      resolve_mispredict = 1'b0;
      resolve_btb_miss = 1'b0;
   endtask

   task automatic fetch_and_check(input logic [31:0] pc, input logic hit0, input logic dir0,
                                  input logic [31:0] npc);
      @(negedge clk);
      fetch_pc = pc;
      #2;
      expect_value("slot0_hit", 32'(slot0_hit), 32'(hit0));
      expect_value("slot0_taken", 32'(slot0_taken), 32'(dir0));
      expect_value("next_pc", next_pc, npc);
   endtask

   task automatic finish_test(input string name);
      $display("test %s: %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   initial begin
      logic [hw-1:0] gh;
      int n;
      lfsr = 32'h8dc2;
      errors = 0;
      checks = 0;
      test_errors = 0;
      fetch_pc = 32'h0000_1000;
      fetch_valid = 1'b0;
      resolve_req = 1'b0;
      resolve_pc = '0;
      resolve_taken = 1'b0;
      resolve_target = '0;
      resolve_mispredict = 1'b0;
      resolve_btb_miss = 1'b0;
      resolve_ghsr = '0;
      n = 0;
      while (reset_n !== 1'b1 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (reset_n !== 1'b1) begin
         $display("timeout: reset_n was never released");
         $display("Regression failed");
         $finish;
      end

      fetch_valid = 1'b1;
      fetch_and_check(32'h0000_1000, 1'b0, 1'b1, 32'h0000_1008);
      expect_value("ghsr_checkpoint", 32'(ghsr_checkpoint), 32'h0);
      expect_value("resolve_ack", 32'(resolve_ack), 32'h0);
      fetch_valid = 1'b0;
      finish_test("reset");

      send_resolution(32'h2000, 1'b1, 32'h3000, 1'b0, 1'b1, ghsr_checkpoint, 0);
      fetch_and_check(32'h2000, 1'b1, 1'b1, 32'h3000);
      fetch_and_check(32'h1ffc, 1'b0, 1'b1, 32'h3000);  // slot 1 redirects
      finish_test("btb_alloc");

      gh = ghsr_checkpoint;
      send_resolution(32'h2400, 1'b1, 32'h2800, 1'b0, 1'b0, gh, 0);  // counter to 3
      repeat (4) send_resolution(32'h2400, 1'b0, 32'h0, 1'b0, 1'b0, gh, 0);
      gh = ghsr_checkpoint;
      fetch_and_check(32'h2400, 1'b1, 1'b0, 32'h2408);
      send_resolution(32'h2400, 1'b1, 32'h2800, 1'b0, 1'b0, gh, 0);
      fetch_and_check(32'h2400, 1'b1, 1'b0, 32'h2408);  // 0 to 1, no wrap
      finish_test("counter");

      for (int i = 0; i < 200; i++)
         send_resolution(32'h1000 + (rand_bits(5) << 2), rand_bits(2) == 0, rand_bits(16),
                         1'b0, 1'b0, hw'(rand_bits(hw)), 0);
      fetch_valid = 1'b1;
      for (int i = 0; i < 60; i++) begin
         @(negedge clk);
         fetch_pc = 32'h1000 + (rand_bits(5) << 2);
      end
      fetch_valid = 1'b0;
      finish_test("spec_history");

      gh = hw'(rand_bits(hw));
      send_resolution(32'h2000, 1'b1, 32'h3000, 1'b1, 1'b0, gh, 0);
      expect_value("ghsr_checkpoint", 32'(ghsr_checkpoint), 32'({gh[hw-2:0], 1'b1}));
      fetch_pc = 32'h2000;
      fetch_valid = 1'b1;  // hitting fetch merges with the btb-miss correction
      send_resolution(32'h1004, 1'b0, 32'h0, 1'b0, 1'b1, hw'(rand_bits(hw)), 0);
      fetch_valid = 1'b0;
      finish_test("correction");

      gh = ghsr_checkpoint;
      repeat (3) send_resolution(32'h2c00, 1'b0, 32'h0, 1'b0, 1'b0, gh, 0);  // counter to 0
      send_resolution(32'h2c00, 1'b1, 32'h2d00, 1'b0, 1'b0, gh, 5);
      fetch_and_check(32'h2c00, 1'b1, 1'b0, 32'h2c08);  // held req stepped once
      send_resolution(32'h2c00, 1'b1, 32'h2d00, 1'b0, 1'b0, gh, 3);
      fetch_and_check(32'h2c00, 1'b1, 1'b1, 32'h2d00);
      finish_test("handshake");

      repeat (2) @(negedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verification
logic/bp_pkg.sv
logic/gshare_predictor.sv
logic/branch_target_buffer.sv
logic/resolve_port.sv
logic/fetch_predictor.sv
verification/clock_gen.sv
verification/fetch_predictor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_predictor_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
